// ==== hni_wdat.f ====
design/chi_dat_pkg.sv
design/hni_wbuf_pkg.sv
design/hni_wdat_alloc.sv
design/hni_wdat_store.sv
design/hni_wdat_drain.sv
design/hni_wdat_top.sv
sim/hni_wdat_assert.sv
sim/hni_wdat_checker.sv
sim/tb_hni_wdat.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_hni_wdat \
    -f hni_wdat.f -o sim_hni_wdat
./obj_dir/sim_hni_wdat > sim.log 2>&1 || true
cat sim.log
grep -q "sim passed" sim.log

// ==== sim/tb_hni_wdat.sv ====
// testbench for the HN-I write data path
// fills entries with CHI flits, drains them onto AXI W and
// keeps a shadow of every line for the checker

`timescale 1ns/1ps

module tb_hni_wdat;

    localparam int NE             = 4;
    localparam int NUM_TXN        = 21;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 40 + RESET_CYCLES;

    logic         clk = 1'b0;
    logic         rst, alloc_en, alloc_device, retire_en, drain_en, rxdat_valid, wready;
    logic [1:0]   alloc_idx, retire_idx, drain_idx;
    logic [47:0]  alloc_addr;
    logic [7:0]   alloc_axlen;
    logic [chi_dat_pkg::FLIT_WIDTH-1:0] rxdat_flit;
    logic         wvalid, wlast, w_done;
    logic [127:0] wdata;
    logic [15:0]  wstrb;
    logic [511:0] exp_line;
    logic [63:0]  exp_strb;
    logic [511:0] line_sh [NE];  // shadow of the written lines
    logic [63:0]  strb_sh [NE];
    logic         alloc_sh [NE];
    logic         rand_ready = 1'b0;
    int           err_count, burst_count, cycles = 0, bursts_exp = 0, tb_errs = 0;
    int           dones_seen = 0;
    int unsigned  seed;
    logic [1:0]   c, order [NE];
    logic [7:0]   len;
    logic         dev;

    hni_wdat_top #(.NUM_ENTRIES(NE)) hni_wdat_top_inst (.*);

    hni_wdat_checker #(.NUM_ENTRIES(NE)) hni_wdat_checker_inst (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end else begin
            #1 wready <= rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    // bursts finished on W so far
    always @(negedge clk) begin
        if (w_done) dones_seen++;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [255:0] rand_data();
        logic [255:0] d;
        for (int i = 0; i < 8; i++) d[i*32 +: 32] = $urandom;
        return d;
    endfunction

    task automatic legal_params(output logic [1:0] cc, output logic [7:0] ln, output logic dv);
        cc = 2'($urandom % 4);
        dv = 1'($urandom % 2);
        if (dv) ln = 8'($urandom_range(0, 3 - int'(cc)));
        else ln = 8'((1 << ($urandom % 3)) - 1);  // n of 1, 2 or 4
    endtask

    task automatic drive_alloc(input logic [1:0] idx, input logic [1:0] cc,
                               input logic [7:0] ln, input logic dv);
        logic [63:0] a;
        a = {$urandom, $urandom};
        a[5:4] = cc;
        step();
        {alloc_en, alloc_idx, alloc_addr, alloc_axlen, alloc_device} = {1'b1, idx, a[47:0], ln, dv};
        alloc_sh[idx] = 1'b1;
        step();
        alloc_en = 1'b0;
    endtask

    task automatic send_flit(input logic [1:0] idx, input logic [1:0] dataid,
                             input logic [255:0] data, input logic [31:0] be);
        int h;
        h = int'(dataid[1]);
        step();
        rxdat_valid = 1'b1;
        rxdat_flit = {data, be, dataid, 6'd0, idx};
        if (alloc_sh[idx] && (dataid == chi_dat_pkg::DATAID_LOW ||
                              dataid == chi_dat_pkg::DATAID_HIGH)) begin
            line_sh[idx][h*256 +: 256] = data;
            strb_sh[idx][h*32 +: 32] = strb_sh[idx][h*32 +: 32] | be;
        end
        step();
        rxdat_valid = 1'b0;
    endtask

    task automatic fill(input logic [1:0] idx, input logic [1:0] mask);
        for (int h = 0; h < 2; h++) begin
            if (mask[h]) begin
                repeat (1 + $urandom % 2)
                    send_flit(idx, h == 1 ? 2'b10 : 2'b00, rand_data(), $urandom);
            end
        end
        if ($urandom % 4 == 0) send_flit(idx, 2'b01, rand_data(), $urandom);  // bad dataid
    endtask

    task automatic drain_retire(input logic [1:0] idx, input logic do_drain);
        step();
        if (do_drain) begin
            {drain_en, drain_idx, exp_line, exp_strb} = {1'b1, idx, line_sh[idx], strb_sh[idx]};
        end else begin
            {retire_en, retire_idx, line_sh[idx], strb_sh[idx]} = {1'b1, idx, 576'd0};
            alloc_sh[idx] = 1'b0;
        end
        step();
        {drain_en, retire_en} = 2'b00;
    endtask

    task automatic wait_done(input int n);
        bursts_exp += n;
        wait (dones_seen >= bursts_exp);
    endtask

    task automatic run_txn(input logic [1:0] idx, input logic [1:0] cc, input logic [7:0] ln,
                           input logic dv, input logic [1:0] mask);
        drive_alloc(idx, cc, ln, dv);
        fill(idx, mask);
        drain_retire(idx, 1'b1);
        wait_done(1);
        drain_retire(idx, 1'b0);
    endtask

    initial begin
        seed = $urandom(32'hb182);
        {rst, alloc_en, alloc_device, retire_en, drain_en, rxdat_valid, wready} = 7'b1000001;
        {alloc_idx, retire_idx, drain_idx, alloc_addr, alloc_axlen} = '0;
        {rxdat_flit, exp_line, exp_strb} = '0;
        for (int e = 0; e < NE; e++) {line_sh[e], strb_sh[e], alloc_sh[e]} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        repeat (5) step();
        for (int k = 0; k < 4; k++) run_txn(2'(k), 2'(k), 8'd3, 1'b0, 2'b11);
        rand_ready = 1'b1;
        for (int k = 0; k < 10; k++) begin
            legal_params(c, len, dev);
            run_txn(2'($urandom % 4), c, len, dev, 2'($urandom % 4));
        end
        rand_ready = 1'b0;
        // same half twice, upper half left empty
        drive_alloc(2'd0, 2'd1, 8'd3, 1'b0);
        send_flit(2'd0, 2'b00, rand_data(), 32'h0000_ffff);
        send_flit(2'd0, 2'b00, rand_data(), 32'hff00_0000);
        drain_retire(2'd0, 1'b1);
        wait_done(1);
        drain_retire(2'd0, 1'b0);
        // all entries pending at once
        rand_ready = 1'b1;
        order = '{2'd1, 2'd3, 2'd0, 2'd2};
        for (int e = 0; e < NE; e++) begin
            legal_params(c, len, dev);
            drive_alloc(2'(e), c, len, dev);
            fill(2'(e), 2'b11);
        end
        step();
        for (int k = 0; k < NE; k++) begin
            {drain_en, drain_idx} = {1'b1, order[k]};
            {exp_line, exp_strb} = {line_sh[order[k]], strb_sh[order[k]]};
            step();
        end
        drain_en = 1'b0;
        wait_done(NE);
        for (int e = 0; e < NE; e++) drain_retire(2'(e), 1'b0);
        rand_ready = 1'b0;
        // stale data after retire, flit to a free entry
        drive_alloc(2'd2, 2'd0, 8'd3, 1'b0);
        fill(2'd2, 2'b11);
        drain_retire(2'd2, 1'b0);
        send_flit(2'd1, 2'b10, rand_data(), 32'hffff_ffff);
        drive_alloc(2'd2, 2'd0, 8'd3, 1'b0);
        drive_alloc(2'd1, 2'd2, 8'd1, 1'b0);
        drain_retire(2'd2, 1'b1);
        wait_done(1);
        drain_retire(2'd1, 1'b1);
        wait_done(1);
        repeat (5) step();
        if (burst_count != bursts_exp) begin
            $display("burst count wrong: %0d seen, %0d expected", burst_count, bursts_exp);
            tb_errs++;
        end
        $display("%0d errors, %0d bursts checked", err_count + tb_errs, burst_count);
        if (err_count + tb_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sim/hni_wdat_checker.sv ====
// W channel checker
// models pending order and beat ranges, compares every cycle at negedge

`timescale 1ns/1ps

module hni_wdat_checker #(
    parameter int  NUM_ENTRIES = 4,
    localparam int IW          = $clog2(NUM_ENTRIES)
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           alloc_en,
    input  logic [IW-1:0]  alloc_idx,
    input  logic [47:0]    alloc_addr,
    input  logic           alloc_device,
    input  logic [7:0]     alloc_axlen,
    input  logic           drain_en,
    input  logic [IW-1:0]  drain_idx,
    input  logic [511:0]   exp_line,
    input  logic [63:0]    exp_strb,
    input  logic           wready,
    input  logic           wvalid,
    input  logic [127:0]   wdata,
    input  logic [15:0]    wstrb,
    input  logic           wlast,
    input  logic           w_done,
    output int             err_count,
    output int             burst_count
);

    logic [1:0]             first_m [NUM_ENTRIES];
    logic [1:0]             last_m  [NUM_ENTRIES];
    logic [511:0]           line_m  [NUM_ENTRIES];
    logic [63:0]            strb_m  [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] pend_m;
    logic                   act_m;
    logic [IW-1:0]          idx_m;
    logic [1:0]             beat_m;

    // first beat in [3:2], last beat in [1:0]
    function automatic logic [3:0] beat_range(input logic [1:0] c, input logic [7:0] axlen,
                                              input logic dev);
        int n;
        int f;
        int l;
        n = int'(axlen) + 1;
        if (dev) begin
            f = int'(c);
            l = (int'(c) + int'(axlen) > 3) ? 3 : int'(c) + int'(axlen);
        end else begin
            f = (int'(c) / n) * n;  // wrap boundary of the burst
            l = f + int'(axlen);
        end
        return {2'(f), 2'(l)};
    endfunction

    always @(negedge clk) begin : check_cycle
        logic [3:0] rng;
        logic       exp_done;
        logic       found;
        if (rst) begin
            pend_m = '0;
            act_m = 1'b0;
            idx_m = '0;
            beat_m = '0;
            err_count = 0;
            burst_count = 0;
        end else begin
            exp_done = act_m && wready && (beat_m == last_m[idx_m]);
            if (wvalid !== act_m) begin
                $display("mismatch at %0t: wvalid %b expected %b", $time, wvalid, act_m);
                err_count++;
            end else if (act_m) begin
                if (wdata !== line_m[idx_m][32'(beat_m)*128 +: 128] ||
                    wstrb !== strb_m[idx_m][32'(beat_m)*16 +: 16]) begin
                    $display("mismatch at %0t: entry %0d beat %0d data %h strb %h", $time,
                             idx_m, beat_m, wdata, wstrb);
                    err_count++;
                end
                if (wlast !== (beat_m == last_m[idx_m])) begin
                    $display("mismatch at %0t: wlast %b on beat %0d", $time, wlast, beat_m);
                    err_count++;
                end
            end
            if (w_done !== exp_done) begin
                $display("mismatch at %0t: w_done %b expected %b", $time, w_done, exp_done);
                err_count++;
            end
            if (w_done && !wlast) begin
                $display("w_done pulsed without a last beat at %0t", $time);
                err_count++;
            end
            // state for the next cycle
            if (alloc_en) begin
                rng = beat_range(alloc_addr[5:4], alloc_axlen, alloc_device);
                first_m[alloc_idx] = rng[3:2];
                last_m[alloc_idx] = rng[1:0];
            end
            if (drain_en) begin
                pend_m[drain_idx] = 1'b1;
                line_m[drain_idx] = exp_line;
                strb_m[drain_idx] = exp_strb;
            end
            if (exp_done) begin
                pend_m[idx_m] = 1'b0;
                burst_count++;
            end
            if (act_m && wready) beat_m = beat_m + 2'd1;
            if (!act_m || exp_done) begin
                found = 1'b0;
                for (int e = 0; e < NUM_ENTRIES; e++) begin
                    if (pend_m[e]) begin
                        found = 1'b1;
                        idx_m = IW'(e);  // highest index ends up picked
                    end
                end
                act_m = found;
                if (found) beat_m = first_m[idx_m];
            end
        end
    end

endmodule

// ==== sim/hni_wdat_assert.sv ====
// AXI W channel protocol checks for the HN-I write data path
// payload holds under back-pressure, wlast and w_done only with a live beat

`timescale 1ns/1ps

module hni_wdat_assert (
    input logic         clk,
    input logic         rst,
    input logic         wvalid,
    input logic         wready,
    input logic [127:0] wdata,
    input logic [15:0]  wstrb,
    input logic         wlast,
    input logic         w_done
);

    a_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("W beat changed while stalled");

    a_last: assert property (@(posedge clk) disable iff (rst) wlast |-> wvalid)
        else $error("wlast without wvalid");

    a_done: assert property (@(posedge clk) disable iff (rst)
        w_done |-> wvalid && wready && wlast)
        else $error("w_done outside a last handshake");

endmodule

bind hni_wdat_top hni_wdat_assert hni_wdat_assert_inst (
    .clk, .rst, .wvalid, .wready, .wdata, .wstrb, .wlast, .w_done
);

// ==== design/hni_wdat_top.sv ====
// HN-I write data path top
// allocation and flit decode, line store and AXI W drain

`timescale 1ns/1ps

module hni_wdat_top #(
    parameter int  NUM_ENTRIES = 4,
    localparam int IDX_WIDTH   = $clog2(NUM_ENTRIES)
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      alloc_en,
    input  logic [IDX_WIDTH-1:0]                      alloc_idx,
    input  logic [hni_wbuf_pkg::ADDR_WIDTH-1:0]       alloc_addr,
    input  logic                                      alloc_device,
    input  logic [hni_wbuf_pkg::AXLEN_WIDTH-1:0]      alloc_axlen,
    input  logic                                      retire_en,
    input  logic [IDX_WIDTH-1:0]                      retire_idx,
    input  logic                                      drain_en,
    input  logic [IDX_WIDTH-1:0]                      drain_idx,
    input  logic                                      rxdat_valid,
    input  logic [chi_dat_pkg::FLIT_WIDTH-1:0]        rxdat_flit,
    input  logic                                      wready,
    output logic                                      wvalid,
    output logic [hni_wbuf_pkg::BEAT_WIDTH-1:0]       wdata,
    output logic [hni_wbuf_pkg::STRB_WIDTH-1:0]       wstrb,
    output logic                                      wlast,
    output logic                                      w_done
);

    logic                                     set_en;
    logic [IDX_WIDTH-1:0]                     set_idx;
    logic [hni_wbuf_pkg::BEAT_IDX_WIDTH-1:0]  set_first;
    logic [hni_wbuf_pkg::BEAT_IDX_WIDTH-1:0]  set_last;
    logic                                     wr_en;
    logic [IDX_WIDTH-1:0]                     wr_idx;
    logic                                     wr_half;
    logic [chi_dat_pkg::FLIT_DATA_WIDTH-1:0]  wr_data;
    logic [chi_dat_pkg::FLIT_BE_WIDTH-1:0]    wr_be;
    logic [IDX_WIDTH-1:0]                     rd_idx;
    hni_wbuf_pkg::line_u                      rd_line;
    hni_wbuf_pkg::strb_u                      rd_strb;

    hni_wdat_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) hni_wdat_alloc_inst (
        .clk, .rst,
        .alloc_en, .alloc_idx, .alloc_addr, .alloc_device, .alloc_axlen,
        .retire_en, .retire_idx,
        .rxdat_valid, .rxdat_flit,
        .set_en, .set_idx, .set_first, .set_last,
        .wr_en, .wr_idx, .wr_half, .wr_data, .wr_be
    );

    hni_wdat_store #(.NUM_ENTRIES(NUM_ENTRIES)) hni_wdat_store_inst (
        .clk, .rst,
        .wr_en, .wr_idx, .wr_half, .wr_data, .wr_be,
        .retire_en, .retire_idx,
        .rd_idx, .rd_line, .rd_strb
    );

    hni_wdat_drain #(.NUM_ENTRIES(NUM_ENTRIES)) hni_wdat_drain_inst (
        .clk, .rst,
        .set_en, .set_idx, .set_first, .set_last,
        .drain_en, .drain_idx,
        .rd_line, .rd_strb,
        .wready,
        .rd_idx, .wvalid, .wdata, .wstrb, .wlast, .w_done
    );

endmodule

// ==== design/hni_wdat_drain.sv ====
// HN-I write data drain
// serves pending entries highest index first and steps the
// active entry's beats onto AXI W, one burst at a time

`timescale 1ns/1ps

module hni_wdat_drain #(
    parameter int  NUM_ENTRIES = 4,
    localparam int IDX_WIDTH   = $clog2(NUM_ENTRIES)
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      set_en,
    input  logic [IDX_WIDTH-1:0]                      set_idx,
    input  logic [hni_wbuf_pkg::BEAT_IDX_WIDTH-1:0]   set_first,
    input  logic [hni_wbuf_pkg::BEAT_IDX_WIDTH-1:0]   set_last,
    input  logic                                      drain_en,
    input  logic [IDX_WIDTH-1:0]                      drain_idx,
    input  hni_wbuf_pkg::line_u                       rd_line,
    input  hni_wbuf_pkg::strb_u                       rd_strb,
    input  logic                                      wready,
    output logic [IDX_WIDTH-1:0]                      rd_idx,
    output logic                                      wvalid,
    output logic [hni_wbuf_pkg::BEAT_WIDTH-1:0]       wdata,
    output logic [hni_wbuf_pkg::STRB_WIDTH-1:0]       wstrb,
    output logic                                      wlast,
    output logic                                      w_done
);

    localparam int BW = hni_wbuf_pkg::BEAT_IDX_WIDTH;

    logic [BW-1:0]          cur_beat  [NUM_ENTRIES];
    logic [BW-1:0]          last_beat [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] pend_q;
    logic [NUM_ENTRIES-1:0] drain_set;
    logic [NUM_ENTRIES-1:0] done_clr;
    logic [NUM_ENTRIES-1:0] cand;
    logic                   act_vld;
    logic [IDX_WIDTH-1:0]   act_idx;
    logic [BW-1:0]          act_beat;
    logic                   pick_vld;
    logic [IDX_WIDTH-1:0]   pick_idx;
    logic                   hs;

    assign act_beat = cur_beat[act_idx];
    assign hs       = act_vld && wready;

    assign drain_set = {{(NUM_ENTRIES - 1){1'b0}}, drain_en} << drain_idx;
    assign done_clr  = {{(NUM_ENTRIES - 1){1'b0}}, w_done} << act_idx;
    assign cand      = (pend_q | drain_set) & ~done_clr;

    // highest pending index wins
    always_comb begin
        pick_vld = 1'b0;
        pick_idx = '0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (cand[e]) begin
                pick_vld = 1'b1;
                pick_idx = IDX_WIDTH'(e);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_q  <= '0;
            act_vld <= 1'b0;
            act_idx <= '0;
        end else begin
            pend_q <= (pend_q & ~done_clr) | drain_set;
            if (!act_vld || w_done) begin  // burst boundary, next entry may start
                act_vld <= pick_vld;
                act_idx <= pick_idx;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                cur_beat[e]  <= '0;
                last_beat[e] <= '0;
            end
        end else begin
            if (hs) begin
                cur_beat[act_idx] <= act_beat + 1'b1;
            end
            if (set_en) begin
                cur_beat[set_idx]  <= set_first;
                last_beat[set_idx] <= set_last;
            end
        end
    end

    assign rd_idx = act_idx;
    assign wvalid = act_vld;
    assign wdata  = rd_line.beat[act_beat];
    assign wstrb  = rd_strb.beat[act_beat];
    assign wlast  = act_vld && (act_beat == last_beat[act_idx]);
    assign w_done = hs && wlast;

endmodule

// ==== design/hni_wdat_store.sv ====
// HN-I write data store
// one 512-bit line and 64 byte enables per entry
// flit writes land in one half, enables accumulate until retire

`timescale 1ns/1ps

module hni_wdat_store #(
    parameter int  NUM_ENTRIES = 4,
    localparam int IDX_WIDTH   = $clog2(NUM_ENTRIES)
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      wr_en,
    input  logic [IDX_WIDTH-1:0]                      wr_idx,
    input  logic                                      wr_half,
    input  logic [2*hni_wbuf_pkg::BEAT_WIDTH-1:0]     wr_data,
    input  logic [2*hni_wbuf_pkg::STRB_WIDTH-1:0]     wr_be,
    input  logic                                      retire_en,
    input  logic [IDX_WIDTH-1:0]                      retire_idx,
    input  logic [IDX_WIDTH-1:0]                      rd_idx,
    output hni_wbuf_pkg::line_u                       rd_line,
    output hni_wbuf_pkg::strb_u                       rd_strb
);

    hni_wbuf_pkg::line_u line_q [NUM_ENTRIES];
    hni_wbuf_pkg::strb_u strb_q [NUM_ENTRIES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                line_q[e] <= '0;
                strb_q[e] <= '0;
            end
        end else begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                if (retire_en && retire_idx == IDX_WIDTH'(e)) begin
                    // retire beats a flit to the same entry
                    line_q[e] <= '0;
                    strb_q[e] <= '0;
                end else if (wr_en && wr_idx == IDX_WIDTH'(e)) begin
                    line_q[e].half[wr_half] <= wr_data;
                    strb_q[e].half[wr_half] <= strb_q[e].half[wr_half] | wr_be;
                end
            end
        end
    end

    // read port feeds the W channel directly
    assign rd_line = line_q[rd_idx];
    assign rd_strb = strb_q[rd_idx];

endmodule

// ==== design/hni_wdat_alloc.sv ====
// HN-I write data allocation
// works out first and last AXI beat of each allocated burst,
// keeps the allocated flags and routes CHI data flits to the store

`timescale 1ns/1ps

module hni_wdat_alloc #(
    parameter int  NUM_ENTRIES = 4,
    localparam int IDX_WIDTH   = $clog2(NUM_ENTRIES)
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      alloc_en,
    input  logic [IDX_WIDTH-1:0]                      alloc_idx,
    input  logic [hni_wbuf_pkg::ADDR_WIDTH-1:0]       alloc_addr,
    input  logic                                      alloc_device,
    input  logic [hni_wbuf_pkg::AXLEN_WIDTH-1:0]      alloc_axlen,
    input  logic                                      retire_en,
    input  logic [IDX_WIDTH-1:0]                      retire_idx,
    input  logic                                      rxdat_valid,
    input  logic [chi_dat_pkg::FLIT_WIDTH-1:0]        rxdat_flit,
    output logic                                      set_en,
    output logic [IDX_WIDTH-1:0]                      set_idx,
    output logic [hni_wbuf_pkg::BEAT_IDX_WIDTH-1:0]   set_first,
    output logic [hni_wbuf_pkg::BEAT_IDX_WIDTH-1:0]   set_last,
    output logic                                      wr_en,
    output logic [IDX_WIDTH-1:0]                      wr_idx,
    output logic                                      wr_half,
    output logic [chi_dat_pkg::FLIT_DATA_WIDTH-1:0]   wr_data,
    output logic [chi_dat_pkg::FLIT_BE_WIDTH-1:0]     wr_be
);

    localparam int BW = hni_wbuf_pkg::BEAT_IDX_WIDTH;
    localparam int LW = hni_wbuf_pkg::AXLEN_WIDTH;

    logic [BW-1:0]                         ccid;
    logic [BW-1:0]                         len_lo;
    logic [LW:0]                           dev_sum;
    logic [NUM_ENTRIES-1:0]                alloc_vld;
    logic [chi_dat_pkg::TXNID_WIDTH-1:0]   rx_txnid;
    logic [chi_dat_pkg::DATAID_WIDTH-1:0]  rx_dataid;
    logic                                  rx_dataid_ok;

    assign ccid    = alloc_addr[hni_wbuf_pkg::CCID_LSB +: BW];
    assign len_lo  = alloc_axlen[BW-1:0];
    assign dev_sum = {1'b0, alloc_axlen} + {{(LW + 1 - BW){1'b0}}, ccid};

    always_comb begin
        if (alloc_device) begin
            set_first = ccid;  // device bursts start at the critical chunk
            if (dev_sum > (LW + 1)'(hni_wbuf_pkg::BEATS_PER_LINE - 1)) begin
                set_last = BW'(hni_wbuf_pkg::BEATS_PER_LINE - 1);
            end else begin
                set_last = dev_sum[BW-1:0];
            end
        end else begin
            // n is 1, 2 or 4 so masking with axlen aligns down
            set_first = ccid & ~len_lo;
            set_last  = (ccid & ~len_lo) + len_lo;
        end
    end

    assign set_en  = alloc_en;
    assign set_idx = alloc_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alloc_vld <= '0;
        end else begin
            if (retire_en) begin
                alloc_vld[retire_idx] <= 1'b0;
            end
            if (alloc_en) begin
                alloc_vld[alloc_idx] <= 1'b1;  // reuse in the retire cycle
            end
        end
    end

    // flit decode
    assign rx_txnid  = rxdat_flit[chi_dat_pkg::TXNID_LSB +: chi_dat_pkg::TXNID_WIDTH];
    assign rx_dataid = rxdat_flit[chi_dat_pkg::DATAID_LSB +: chi_dat_pkg::DATAID_WIDTH];
    assign rx_dataid_ok = (rx_dataid == chi_dat_pkg::DATAID_LOW) ||
                          (rx_dataid == chi_dat_pkg::DATAID_HIGH);

    assign wr_idx  = rx_txnid[IDX_WIDTH-1:0];
    assign wr_en   = rxdat_valid && alloc_vld[wr_idx] && rx_dataid_ok;
    assign wr_half = rx_dataid[1];
    assign wr_data = rxdat_flit[chi_dat_pkg::DATA_LSB +: chi_dat_pkg::FLIT_DATA_WIDTH];
    assign wr_be   = rxdat_flit[chi_dat_pkg::BE_LSB +: chi_dat_pkg::FLIT_BE_WIDTH];

endmodule

// ==== design/hni_wbuf_pkg.sv ====
// HN-I write buffer and AXI W beat definitions
// a line is 512 bits, filled as two flit halves and drained as
// four 128-bit AXI beats

package hni_wbuf_pkg;

    localparam int BEAT_WIDTH     = 128;
    localparam int STRB_WIDTH     = 16;
    localparam int BEATS_PER_LINE = 4;
    localparam int BEAT_IDX_WIDTH = 2;
    localparam int AXLEN_WIDTH    = 8;
    localparam int ADDR_WIDTH     = 48;
    localparam int CCID_LSB       = 4;   // ccid is addr[5:4]

    // half view for flit writes, beat view for the W channel
    typedef union packed {
        logic [1:0][2*BEAT_WIDTH-1:0]              half;
        logic [BEATS_PER_LINE-1:0][BEAT_WIDTH-1:0] beat;
    } line_u;

    typedef union packed {
        logic [1:0][2*STRB_WIDTH-1:0]              half;
        logic [BEATS_PER_LINE-1:0][STRB_WIDTH-1:0] beat;
    } strb_u;

endpackage

// ==== design/chi_dat_pkg.sv ====
// CHI data flit layout
// simplified RXDAT flit carrying one 256-bit half of a line
// fields from lsb: txnid, dataid, byte enables, data

package chi_dat_pkg;

    localparam int TXNID_WIDTH     = 8;
    localparam int DATAID_WIDTH    = 2;
    localparam int FLIT_DATA_WIDTH = 256;
    localparam int FLIT_BE_WIDTH   = 32;

    // field low positions
    localparam int TXNID_LSB  = 0;
    localparam int DATAID_LSB = TXNID_LSB + TXNID_WIDTH;
    localparam int BE_LSB     = DATAID_LSB + DATAID_WIDTH;
    localparam int DATA_LSB   = BE_LSB + FLIT_BE_WIDTH;

    localparam int FLIT_WIDTH = DATA_LSB + FLIT_DATA_WIDTH;

    // dataid picks the half of the 512-bit line
    localparam logic [DATAID_WIDTH-1:0] DATAID_LOW  = 2'b00;
    localparam logic [DATAID_WIDTH-1:0] DATAID_HIGH = 2'b10;

endpackage
